/* drs_pkg.sv */
`default_nettype none

package drs_pkg;

  // ----------------------------------------
  // widths and timing
  // ----------------------------------------

  localparam int ADC_WIDTH = 14;
  // eight signal channels plus channel 8
  localparam int NUM_CHANNELS = 9;
  localparam int CHAN_WIDTH = 4;
  localparam int CELL_WIDTH = 10;
  localparam int LATENCY_WIDTH = 6;
  // negedge capture flop plus posedge retime flop
  localparam int ADC_CAPTURE_DELAY = 2;
  // about 1.5 domino turns before the trigger is armed
  localparam int DOMINO_SETTLE_CYCLES = 106;
  // chip reset low time from the datasheet
  localparam int NRESET_CYCLES = 2;
  localparam int SR_BITS = 8;
  // reserved config bits 7..3 must always be written as ones
  localparam logic [4:0] CONFIG_FORCED_ONES = 5'b11111;

  // counter widths
  localparam int TIMER_WIDTH = $clog2(DOMINO_SETTLE_CYCLES);
  localparam int SR_CNT_WIDTH = $clog2(SR_BITS);
  // room for samples plus latency plus capture delay
  localparam int READ_CNT_WIDTH = CELL_WIDTH + 1;

  // ----------------------------------------
  // chip addresses
  // ----------------------------------------

  // channels 0..8 use their plain number as address
  typedef enum logic [CHAN_WIDTH-1:0] {
    ADDR_READ_SR  = 4'b1011,
    ADDR_CONFIG   = 4'b1100,
    ADDR_WRITE_SR = 4'b1101,
    ADDR_STANDBY  = 4'b1111
  } addr_e;

  typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

  // user settings, held static while busy
  typedef struct packed {
    // 1 keeps the domino cycling until a trigger
    logic                     dmode_cont;
    logic                     standby;
    logic [7:0]               config_reg;
    // write shift register channel pattern
    logic [7:0]               chn_pattern;
    logic [7:0]               readout_mask;
    logic [CELL_WIDTH-1:0]    samples;
    // srclk cycles until the ADC shows the first sample
    logic [LATENCY_WIDTH-1:0] adc_latency;
  } drs_ctl_t;

  // chip control pins, srclk_en and srin travel on their own
  typedef struct packed {
    logic [CHAN_WIDTH-1:0] addr;
    logic                  nreset;
    logic                  denable;
    logic                  dwrite;
    logic                  rsrload;
    logic                  on;
  } drs_pins_t;

  // config register layout, bit 0 first from the bottom
  typedef struct packed {
    logic [4:0] reserved;
    logic       wsrloop;
    logic       pllen;
    logic       dmode;
  } config_fields_t;

  // one serializer word, raw or as config register
  typedef union packed {
    logic [SR_BITS-1:0] raw;
    config_fields_t     cfg;
  } sr_word_u;

endpackage

`default_nettype wire

/* drs_channel_mask.sv */
`default_nettype none

module drs_channel_mask
  import drs_pkg::*;
(
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  chan_mask_t            mask_i,
  input  logic                  start_i,
  input  logic                  retire_i,
  output logic [CHAN_WIDTH-1:0] chan_o,
  output logic                  last_o
);

  // channels still waiting for readout
  chan_mask_t pending_q;
  chan_mask_t start_mask;

  // channel 8 rides along whenever anything is enabled
  always_comb begin
    start_mask = mask_i;
    start_mask[NUM_CHANNELS-1] = |mask_i;
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else if (start_i) begin
      pending_q <= start_mask;
    end else if (retire_i) begin
      // drop the channel just read
      pending_q[chan_o] <= 1'b0;
    end
  end

  // ----------------------------------------
  // next channel lookup
  // ----------------------------------------

  // lowest pending bit wins, scan from the top down
  always_comb begin
    chan_o = '0;
    for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        chan_o = CHAN_WIDTH'(i);
      end
    end
  end

  // exactly one bit left means current is the last
  assign last_o = (pending_q != '0) && ((pending_q & (pending_q - 1'b1)) == '0);

endmodule

`default_nettype wire

/* drs_serializer.sv */
`default_nettype none

module drs_serializer
  import drs_pkg::*;
(
  input  logic     clock_i,
  input  logic     reset_i,
  input  logic     load_i,
  input  sr_word_u word_i,
  output logic     srclk_en_o,
  output logic     srin_o,
  output logic     busy_o
);

  logic [SR_BITS-1:0]      shift_q;
  logic [SR_CNT_WIDTH-1:0] bit_cnt_q;
  logic                    active_q;

  // bit counter, one srclk per bit
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      active_q  <= 1'b0;
      bit_cnt_q <= '0;
    end else if (load_i) begin
      active_q  <= 1'b1;
      bit_cnt_q <= '0;
    end else if (active_q) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
      if (bit_cnt_q == SR_CNT_WIDTH'(SR_BITS - 1)) begin
        active_q <= 1'b0;
      end
    end
  end

  // msb sits on srin while its clock is enabled
  always_ff @(posedge clock_i) begin
    if (load_i) begin
      shift_q <= word_i.raw;
    end else if (active_q) begin
      shift_q <= {shift_q[SR_BITS-2:0], 1'b0};
    end
  end

  assign srclk_en_o = active_q;
  assign srin_o     = shift_q[SR_BITS-1];
  assign busy_o     = active_q;

  // sequencer must wait for the previous word
  a_no_load_while_busy : assert property (
    @(posedge clock_i) disable iff (reset_i)
    load_i |-> !busy_o
  );

endmodule

`default_nettype wire

/* drs_sequencer.sv */
`default_nettype none

module drs_sequencer
  import drs_pkg::*;
(
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  drs_ctl_t              ctl_i,
  input  logic                  start_i,
  input  logic                  configure_i,
  input  logic                  reinit_i,
  input  logic                  trigger_i,
  input  logic                  ser_busy_i,
  input  logic                  ser_srclk_en_i,
  input  logic                  ser_srin_i,
  input  logic                  gate_srclk_en_i,
  input  logic [CHAN_WIDTH-1:0] chan_i,
  input  logic                  last_i,
  input  logic                  chan_done_i,
  output logic                  ser_load_o,
  output sr_word_u              ser_word_o,
  output logic                  mask_start_o,
  output logic                  mask_retire_o,
  output logic                  gate_start_o,
  output logic                  roi_first_o,
  output drs_pins_t             pins_o,
  output logic                  srclk_en_o,
  output logic                  srin_o,
  output logic                  busy_o,
  output logic                  done_o
);

  typedef enum logic [3:0] {
    ST_INIT,
    ST_IDLE,
    ST_CONFIG,
    ST_WSR,
    ST_START_RUN,
    ST_RUNNING,
    ST_ADDR_SETUP,
    ST_RSR_LOAD,
    ST_SAMPLE,
    ST_STOP_CELL,
    ST_DONE,
    ST_STANDBY
  } state_e;

  state_e                 state_q;
  logic [TIMER_WIDTH-1:0] tmr_q;
  logic                   reinit_req_q;
  logic                   any_chan;
  logic                   go_readout;
  sr_word_u               cfg_word;

  // config byte with the reserved field forced high
  always_comb begin
    cfg_word.raw = ctl_i.config_reg;
    cfg_word.cfg.reserved = CONFIG_FORCED_ONES;
  end

  assign any_chan = |ctl_i.readout_mask;
  // armed trigger, or single shot reads at once
  assign go_readout = (trigger_i && any_chan) || !ctl_i.dmode_cont;

  // mask block answers on the next cycle, in time for address setup
  assign mask_start_o  = (state_q == ST_RUNNING) && go_readout && any_chan;
  assign mask_retire_o = (state_q == ST_SAMPLE) && chan_done_i && !last_i;

  // ----------------------------------------
  // main FSM
  // ----------------------------------------

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q        <= ST_INIT;
      tmr_q          <= '0;
      reinit_req_q   <= 1'b0;
      roi_first_o    <= 1'b0;
      ser_load_o     <= 1'b0;
      gate_start_o   <= 1'b0;
      busy_o         <= 1'b0;
      done_o         <= 1'b0;
      pins_o.addr    <= ADDR_STANDBY;
      pins_o.nreset  <= 1'b0;
      pins_o.denable <= 1'b0;
      pins_o.dwrite  <= 1'b0;
      pins_o.rsrload <= 1'b0;
      pins_o.on      <= 1'b1;
    end else begin
      ser_load_o   <= 1'b0;
      gate_start_o <= 1'b0;
      done_o       <= 1'b0;
      // reinit is a strobe, hold it until a safe state
      if (reinit_i) begin
        reinit_req_q <= 1'b1;
      end

      case (state_q)
        ST_INIT: begin
          pins_o.addr    <= ADDR_STANDBY;
          pins_o.nreset  <= 1'b0;
          pins_o.denable <= 1'b0;
          pins_o.dwrite  <= 1'b0;
          pins_o.rsrload <= 1'b0;
          busy_o         <= 1'b0;
          reinit_req_q   <= 1'b0;
          tmr_q          <= tmr_q + 1'b1;
          if (tmr_q == TIMER_WIDTH'(NRESET_CYCLES - 1)) begin
            pins_o.nreset <= 1'b1;
            tmr_q         <= '0;
            state_q       <= ST_IDLE;
          end
        end

        ST_IDLE: begin
          if (reinit_req_q) begin
            tmr_q   <= '0;
            state_q <= ST_INIT;
          end else if (ctl_i.standby) begin
            pins_o.addr    <= ADDR_STANDBY;
            pins_o.on      <= 1'b0;
            pins_o.denable <= 1'b0;
            pins_o.dwrite  <= 1'b0;
            state_q        <= ST_STANDBY;
          end else if (configure_i) begin
            pins_o.addr <= ADDR_CONFIG;
            ser_word_o  <= cfg_word;
            ser_load_o  <= 1'b1;
            state_q     <= ST_CONFIG;
          end else if (start_i) begin
            // start the domino wave and sample
            pins_o.addr    <= ADDR_READ_SR;
            pins_o.denable <= 1'b1;
            pins_o.dwrite  <= 1'b1;
            busy_o         <= 1'b1;
            tmr_q          <= '0;
            state_q        <= ST_START_RUN;
          end
        end

        // config byte out, then the channel pattern
        ST_CONFIG: begin
          if (!ser_load_o && !ser_busy_i) begin
            pins_o.addr    <= ADDR_WRITE_SR;
            ser_word_o.raw <= ctl_i.chn_pattern;
            ser_load_o     <= 1'b1;
            state_q        <= ST_WSR;
          end
        end

        ST_WSR: begin
          if (!ser_load_o && !ser_busy_i) begin
            state_q <= ST_IDLE;
          end
        end

        // let the domino settle before arming
        ST_START_RUN: begin
          tmr_q <= tmr_q + 1'b1;
          if (reinit_req_q) begin
            tmr_q   <= '0;
            state_q <= ST_INIT;
          end else if (tmr_q == TIMER_WIDTH'(DOMINO_SETTLE_CYCLES - 1)) begin
            state_q <= ST_RUNNING;
          end
        end

        // armed, waiting for trigger
        ST_RUNNING: begin
          if (reinit_req_q) begin
            tmr_q   <= '0;
            state_q <= ST_INIT;
          end else if (ctl_i.standby) begin
            busy_o  <= 1'b0;
            state_q <= ST_IDLE;
          end else if (go_readout) begin
            // freeze the sampling cells
            pins_o.dwrite <= 1'b0;
            roi_first_o   <= 1'b1;
            state_q       <= any_chan ? ST_ADDR_SETUP : ST_STOP_CELL;
          end
        end

        ST_ADDR_SETUP: begin
          pins_o.addr <= chan_i;
          state_q     <= ST_RSR_LOAD;
        end

        // rsrload and gate start share one cycle
        ST_RSR_LOAD: begin
          pins_o.rsrload <= 1'b1;
          gate_start_o   <= 1'b1;
          state_q        <= ST_SAMPLE;
        end

        ST_SAMPLE: begin
          pins_o.rsrload <= 1'b0;
          if (chan_done_i) begin
            roi_first_o <= 1'b0;
            state_q     <= last_i ? ST_STOP_CELL : ST_ADDR_SETUP;
          end
        end

        // stop cell register in the gate is settled by now
        ST_STOP_CELL: begin
          pins_o.addr <= ADDR_READ_SR;
          busy_o      <= 1'b0;
          done_o      <= 1'b1;
          state_q     <= ST_DONE;
        end

        ST_DONE: begin
          // keep the chip sampling between events
          pins_o.dwrite <= 1'b1;
          state_q       <= ST_IDLE;
        end

        ST_STANDBY: begin
          if (!ctl_i.standby) begin
            pins_o.on <= 1'b1;
            state_q   <= ST_IDLE;
          end
        end

        default: begin
          state_q <= ST_INIT;
        end
      endcase
    end
  end

  // ----------------------------------------
  // shift clock source
  // ----------------------------------------

  always_comb begin
    srclk_en_o = 1'b0;
    srin_o     = 1'b0;
    case (state_q)
      ST_CONFIG, ST_WSR: begin
        srclk_en_o = ser_srclk_en_i;
        srin_o     = ser_srin_i;
      end
      ST_SAMPLE: begin
        srclk_en_o = gate_srclk_en_i;
      end
      default: begin
        srclk_en_o = 1'b0;
      end
    endcase
  end

  // busy drops as done shows, and done lasts one cycle
  a_done_single : assert property (
    @(posedge clock_i) disable iff (reset_i)
    done_o |-> (!busy_o && $past(busy_o)) ##1 !done_o
  );

endmodule

`default_nettype wire

/* drs_sample_gate.sv */
`default_nettype none

module drs_sample_gate
  import drs_pkg::*;
(
  input  logic                     clock_i,
  input  logic                     reset_i,
  input  logic [ADC_WIDTH-1:0]     adc_data_i,
  input  logic                     srout_i,
  input  logic                     start_i,
  input  logic                     roi_first_i,
  input  logic [CELL_WIDTH-1:0]    samples_i,
  input  logic [LATENCY_WIDTH-1:0] latency_i,
  output logic                     srclk_en_o,
  output logic [ADC_WIDTH-1:0]     fifo_wdata_o,
  output logic                     fifo_wen_o,
  output logic [CELL_WIDTH-1:0]    stop_cell_o,
  output logic                     chan_done_o
);

  logic [ADC_WIDTH-1:0]      adc_neg_q;
  logic [ADC_WIDTH-1:0]      adc_pos_q;
  logic                      active_q;
  logic                      first_q;
  logic [READ_CNT_WIDTH-1:0] rd_cnt_q;
  logic [READ_CNT_WIDTH-1:0] win_start;
  logic [READ_CNT_WIDTH-1:0] last_rd;
  logic [CELL_WIDTH-1:0]     stop_sh_q;
  logic                      in_window;
  logic                      last_cycle;

  // ----------------------------------------
  // ADC capture
  // ----------------------------------------

  // adc clock is in phase with ours, take data mid cycle
  always_ff @(negedge clock_i) begin
    adc_neg_q <= adc_data_i;
  end

  always_ff @(posedge clock_i) begin
    adc_pos_q <= adc_neg_q;
  end

  // ----------------------------------------
  // readout window
  // ----------------------------------------

  // rd_cnt counts enabled srclk cycles from 0
  // sample k is in adc_pos_q at count k + latency + 1
  assign win_start = READ_CNT_WIDTH'(latency_i) + READ_CNT_WIDTH'(ADC_CAPTURE_DELAY - 1);
  assign last_rd = READ_CNT_WIDTH'(samples_i) + READ_CNT_WIDTH'(latency_i)
                 + READ_CNT_WIDTH'(ADC_CAPTURE_DELAY - 1);
  assign in_window  = active_q && (rd_cnt_q >= win_start) && (rd_cnt_q < last_rd);
  assign last_cycle = active_q && (rd_cnt_q == last_rd);
  assign srclk_en_o = active_q;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      active_q    <= 1'b0;
      first_q     <= 1'b0;
      rd_cnt_q    <= '0;
      fifo_wen_o  <= 1'b0;
      chan_done_o <= 1'b0;
      stop_cell_o <= '0;
    end else begin
      fifo_wen_o  <= in_window;
      chan_done_o <= last_cycle;
      // stop cell only comes with the first channel, last bit is in by now
      if (chan_done_o && first_q) begin
        stop_cell_o <= stop_sh_q;
      end
      if (start_i) begin
        active_q <= 1'b1;
        first_q  <= roi_first_i;
        rd_cnt_q <= '0;
      end else if (active_q) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
        if (last_cycle) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // stop cell msb first, srout sampled in its enabled cycle
  always_ff @(posedge clock_i) begin
    if (active_q && first_q && (rd_cnt_q < READ_CNT_WIDTH'(CELL_WIDTH))) begin
      stop_sh_q <= {stop_sh_q[CELL_WIDTH-2:0], srout_i};
    end
  end

  always_ff @(posedge clock_i) begin
    if (in_window) begin
      fifo_wdata_o <= adc_pos_q;
    end
  end

  // a written word went through both capture flops inside the readout clocks
  a_wen_in_sample : assert property (
    @(posedge clock_i) disable iff (reset_i)
    fifo_wen_o |-> $past(srclk_en_o, ADC_CAPTURE_DELAY)
  );

endmodule

`default_nettype wire

/* drs_top.sv */
`default_nettype none

module drs_top
  import drs_pkg::*;
(
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  drs_ctl_t              ctl_i,
  input  logic                  start_i,
  input  logic                  configure_i,
  input  logic                  reinit_i,
  input  logic                  trigger_i,
  input  logic [ADC_WIDTH-1:0]  adc_data_i,
  input  logic                  srout_i,
  output drs_pins_t             pins_o,
  output logic                  srclk_en_o,
  output logic                  srin_o,
  output logic [ADC_WIDTH-1:0]  fifo_wdata_o,
  output logic                  fifo_wen_o,
  output logic [CELL_WIDTH-1:0] stop_cell_o,
  output logic                  busy_o,
  output logic                  done_o
);

  // sequencer to serializer
  logic     ser_load;
  sr_word_u ser_word;
  logic     ser_busy;
  logic     ser_srclk_en;
  logic     ser_srin;

  // sequencer to channel mask
  chan_mask_t            user_mask;
  logic                  mask_start;
  logic                  mask_retire;
  logic [CHAN_WIDTH-1:0] chan;
  logic                  last;

  // sequencer to sample gate
  logic gate_start;
  logic roi_first;
  logic gate_srclk_en;
  logic chan_done;

  // channel 8 is added inside the mask block
  assign user_mask = {1'b0, ctl_i.readout_mask};

  drs_sequencer u_sequencer (
    .clock_i         (clock_i),
    .reset_i         (reset_i),
    .ctl_i           (ctl_i),
    .start_i         (start_i),
    .configure_i     (configure_i),
    .reinit_i        (reinit_i),
    .trigger_i       (trigger_i),
    .ser_busy_i      (ser_busy),
    .ser_srclk_en_i  (ser_srclk_en),
    .ser_srin_i      (ser_srin),
    .gate_srclk_en_i (gate_srclk_en),
    .chan_i          (chan),
    .last_i          (last),
    .chan_done_i     (chan_done),
    .ser_load_o      (ser_load),
    .ser_word_o      (ser_word),
    .mask_start_o    (mask_start),
    .mask_retire_o   (mask_retire),
    .gate_start_o    (gate_start),
    .roi_first_o     (roi_first),
    .pins_o          (pins_o),
    .srclk_en_o      (srclk_en_o),
    .srin_o          (srin_o),
    .busy_o          (busy_o),
    .done_o          (done_o)
  );

  drs_channel_mask u_channel_mask (
    .clock_i  (clock_i),
    .reset_i  (reset_i),
    .mask_i   (user_mask),
    .start_i  (mask_start),
    .retire_i (mask_retire),
    .chan_o   (chan),
    .last_o   (last)
  );

  drs_serializer u_serializer (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .load_i     (ser_load),
    .word_i     (ser_word),
    .srclk_en_o (ser_srclk_en),
    .srin_o     (ser_srin),
    .busy_o     (ser_busy)
  );

  drs_sample_gate u_sample_gate (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .adc_data_i   (adc_data_i),
    .srout_i      (srout_i),
    .start_i      (gate_start),
    .roi_first_i  (roi_first),
    .samples_i    (ctl_i.samples),
    .latency_i    (ctl_i.adc_latency),
    .srclk_en_o   (gate_srclk_en),
    .fifo_wdata_o (fifo_wdata_o),
    .fifo_wen_o   (fifo_wen_o),
    .stop_cell_o  (stop_cell_o),
    .chan_done_o  (chan_done)
  );

endmodule

`default_nettype wire

/* drs_chip_model.sv */
`default_nettype none

module drs_chip_model
  import drs_pkg::*;
(
  input  logic                     clock_i,
  input  logic                     reset_i,
  input  drs_pins_t                pins_i,
  input  logic                     srclk_en_i,
  input  logic                     srin_i,
  input  logic [LATENCY_WIDTH-1:0] latency_i,
  output logic [ADC_WIDTH-1:0]     adc_data_o,
  output logic                     srout_o,
  output logic [CELL_WIDTH-1:0]    stop_cell_o,
  output logic [7:0]               cfg_word_o,
  output logic [7:0]               cfg_cnt_o,
  output logic [7:0]               wsr_word_o,
  output logic [7:0]               wsr_cnt_o
);

  // one slot per possible latency value
  localparam int RING_DEPTH = 2 ** LATENCY_WIDTH;

  logic [ADC_WIDTH-1:0]     adc_ring [RING_DEPTH];
  logic [LATENCY_WIDTH-1:0] wr_ptr;
  logic [LATENCY_WIDTH-1:0] rd_ptr;
  logic [CELL_WIDTH-1:0]    cell_sh;
  logic [CELL_WIDTH-1:0]    clk_idx;
  logic [ADC_WIDTH-1:0]     sample;
  logic                     dwrite_q;

  // ----------------------------------------
  // chip and ADC behaviour
  // ----------------------------------------

  // pins are settled two units after the edge
  always @(posedge clock_i) begin
    #2;
    if (reset_i) begin
      wr_ptr      = '0;
      cell_sh     = '0;
      clk_idx     = '0;
      dwrite_q    = 1'b0;
      adc_data_o  = '0;
      srout_o     = 1'b0;
      stop_cell_o = '0;
      cfg_word_o  = '0;
      cfg_cnt_o   = '0;
      wsr_word_o  = '0;
      wsr_cnt_o   = '0;
      for (int i = 0; i < RING_DEPTH; i++) begin
        adc_ring[i] = '0;
      end
    end else begin
      // domino stops, a new stop cell for this event
      if (dwrite_q && !pins_i.dwrite) begin
        stop_cell_o = CELL_WIDTH'($urandom_range(2 ** CELL_WIDTH - 1, 0));
      end
      dwrite_q = pins_i.dwrite;

      // read shift register load restarts the readout clock count
      if (pins_i.rsrload) begin
        cell_sh = stop_cell_o;
        clk_idx = '0;
      end

      sample = '0;
      if (srclk_en_i) begin
        case (pins_i.addr)
          ADDR_CONFIG: begin
            cfg_word_o = {cfg_word_o[6:0], srin_i};
            cfg_cnt_o  = cfg_cnt_o + 8'd1;
          end
          ADDR_WRITE_SR: begin
            wsr_word_o = {wsr_word_o[6:0], srin_i};
            wsr_cnt_o  = wsr_cnt_o + 8'd1;
          end
          default: begin
            // channel read, address up top and clock index below
            sample  = {pins_i.addr, clk_idx};
            // stop cell msb first, one bit per readout clock
            srout_o = cell_sh[CELL_WIDTH-1];
            cell_sh = {cell_sh[CELL_WIDTH-2:0], 1'b0};
            clk_idx = clk_idx + 10'd1;
          end
        endcase
      end

      // adc pipeline, latency 0 shows the sample at once
      adc_ring[wr_ptr] = sample;
      rd_ptr           = wr_ptr - latency_i;
      adc_data_o       = adc_ring[rd_ptr];
      wr_ptr           = wr_ptr + 6'd1;
    end
  end

endmodule

`default_nettype wire

/* tb_drs.sv */
`default_nettype none

module tb_drs
  import drs_pkg::*;
();

  localparam int CLK_HALF = 5;
  localparam int RESET_CYCLES = 5;
  // nine long channels plus the settle time fit well inside
  localparam int WAIT_LIMIT = 4000;
  // armed for a while before the trigger comes
  localparam int ARMED_HOLD = 150;
  localparam int SEL_START = 0;
  localparam int SEL_CONFIGURE = 1;
  localparam int SEL_TRIGGER = 2;

  logic                  clock;
  logic                  reset;
  drs_ctl_t              ctl;
  logic                  start;
  logic                  configure;
  logic                  reinit;
  logic                  trigger;
  logic [ADC_WIDTH-1:0]  adc_data;
  logic                  srout;
  drs_pins_t             pins;
  logic                  srclk_en;
  logic                  srin;
  logic [ADC_WIDTH-1:0]  fifo_wdata;
  logic                  fifo_wen;
  logic [CELL_WIDTH-1:0] stop_cell;
  logic                  busy;
  logic                  done;

  // chip model side
  logic [CELL_WIDTH-1:0] model_stop_cell;
  logic [7:0]            cfg_word;
  logic [7:0]            cfg_cnt;
  logic [7:0]            wsr_word;
  logic [7:0]            wsr_cnt;

  logic [ADC_WIDTH-1:0]  exp_q [$];
  logic [ADC_WIDTH-1:0]  exp_word;
  int                    err_cnt = 0;
  int                    chk_cnt = 0;
  int                    test_cnt = 0;
  int                    test_err_base = 0;
  int                    done_cnt = 0;
  int                    seed_ret;

  // ----------------------------------------
  // clock and instances
  // ----------------------------------------

  initial begin
    clock = 1'b0;
    forever #CLK_HALF clock = ~clock;
  end

  drs_top uut (
    .clock_i      (clock),
    .reset_i      (reset),
    .ctl_i        (ctl),
    .start_i      (start),
    .configure_i  (configure),
    .reinit_i     (reinit),
    .trigger_i    (trigger),
    .adc_data_i   (adc_data),
    .srout_i      (srout),
    .pins_o       (pins),
    .srclk_en_o   (srclk_en),
    .srin_o       (srin),
    .fifo_wdata_o (fifo_wdata),
    .fifo_wen_o   (fifo_wen),
    .stop_cell_o  (stop_cell),
    .busy_o       (busy),
    .done_o       (done)
  );

  drs_chip_model u_chip (
    .clock_i     (clock),
    .reset_i     (reset),
    .pins_i      (pins),
    .srclk_en_i  (srclk_en),
    .srin_i      (srin),
    .latency_i   (ctl.adc_latency),
    .adc_data_o  (adc_data),
    .srout_o     (srout),
    .stop_cell_o (model_stop_cell),
    .cfg_word_o  (cfg_word),
    .cfg_cnt_o   (cfg_cnt),
    .wsr_word_o  (wsr_word),
    .wsr_cnt_o   (wsr_cnt)
  );

  // ----------------------------------------
  // expected words and comparison
  // ----------------------------------------

  // ascending enabled channels, channel 8 last, index from 0 per channel
  function automatic void build_expected(input logic [7:0] mask,
                                         input logic [CELL_WIDTH-1:0] samples);
    logic [NUM_CHANNELS-1:0] full;
    full = {|mask, mask};
    exp_q.delete();
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      if (full[ch]) begin
        for (int i = 0; i < int'(samples); i++) begin
          exp_q.push_back({CHAN_WIDTH'(ch), CELL_WIDTH'(i)});
        end
      end
    end
  endfunction

  // outputs are stable mid cycle
  always @(negedge clock) begin
    if (!reset && fifo_wen) begin
      chk_cnt++;
      assert (exp_q.size() > 0) else begin
        $display("FIFO write of %h came when no word was expected", fifo_wdata);
        err_cnt++;
      end
      // cells are frozen for the whole readout
      assert (pins.dwrite === 1'b0) else begin
        $display("FIFO write came while dwrite was still high");
        err_cnt++;
      end
      if (exp_q.size() > 0) begin
        exp_word = exp_q.pop_front();
        assert (fifo_wdata === exp_word) else begin
          $display("FAILED fifo_wdata_o: got %h expected %h", fifo_wdata, exp_word);
          err_cnt++;
        end
      end
    end
    if (!reset && done) begin
      done_cnt++;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // one cycle strobe on the selected input
  task automatic strobe(input int sel);
    next_cycle();
    case (sel)
      SEL_START: start = 1'b1;
      SEL_CONFIGURE: configure = 1'b1;
      default: trigger = 1'b1;
    endcase
    next_cycle();
    start     = 1'b0;
    configure = 1'b0;
    trigger   = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    chk_cnt++;
    assert (got === want) else begin
      $display("FAILED %s: got %h expected %h", name, got, want);
      err_cnt++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic wait_for_done();
    int n;
    n = 0;
    @(negedge clock);
    while (!done && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (!done) begin
      abort_on_timeout("done_o");
    end
  endtask

  task automatic wait_for_power(input logic level);
    int n;
    n = 0;
    @(negedge clock);
    while (pins.on !== level && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (pins.on !== level) begin
      abort_on_timeout("the on pin");
    end
  endtask

  task automatic wait_for_wsr();
    int n;
    n = 0;
    @(negedge clock);
    while (wsr_cnt < 8'd8 && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (wsr_cnt < 8'd8) begin
      abort_on_timeout("the write shift register bits");
    end
  endtask

  task automatic randomize_readout();
    ctl.readout_mask = 8'($urandom_range(255, 1));
    ctl.samples      = CELL_WIDTH'($urandom_range(40, 8));
    ctl.adc_latency  = LATENCY_WIDTH'($urandom_range(15, 0));
  endtask

  // done and the full word list, then quiet
  task automatic finish_readout(input int done_base);
    wait_for_done();
    check_value("busy_o", busy, 1'b0);
    repeat (4) @(negedge clock);
    chk_cnt++;
    assert (exp_q.size() == 0) else begin
      $display("%0d expected FIFO words never arrived", exp_q.size());
      err_cnt++;
    end
    chk_cnt++;
    assert (done_cnt == done_base + 1) else begin
      $display("done_o pulsed %0d times instead of once", done_cnt - done_base);
      err_cnt++;
    end
  endtask

  task automatic run_single_shot();
    int done_base;
    build_expected(ctl.readout_mask, ctl.samples);
    done_base = done_cnt;
    strobe(SEL_START);
    @(negedge clock);
    check_value("busy_o", busy, 1'b1);
    finish_readout(done_base);
  endtask

  task automatic begin_test();
    test_cnt++;
    test_err_base = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    int done_base;
    seed_ret        = $urandom(62);
    reset           = 1'b1;
    start           = 1'b0;
    configure       = 1'b0;
    reinit          = 1'b0;
    trigger         = 1'b0;
    ctl             = '0;
    ctl.config_reg  = 8'($urandom);
    ctl.chn_pattern = 8'($urandom);
    ctl.samples     = CELL_WIDTH'(16);
    ctl.adc_latency = LATENCY_WIDTH'(4);
    repeat (RESET_CYCLES) next_cycle();
    reset = 1'b0;

    // quiet after reset, nothing until start
    begin_test();
    @(negedge clock);
    check_value("busy_o", busy, 1'b0);
    check_value("done_o", done, 1'b0);
    check_value("fifo_wen_o", fifo_wen, 1'b0);
    check_value("pins_o.denable", pins.denable, 1'b0);
    check_value("pins_o.dwrite", pins.dwrite, 1'b0);
    check_value("pins_o.rsrload", pins.rsrload, 1'b0);
    check_value("srclk_en_o", srclk_en, 1'b0);
    check_value("pins_o.on", pins.on, 1'b1);
    // chip reset still held low
    check_value("pins_o.nreset", pins.nreset, 1'b0);
    check_value("pins_o.addr", pins.addr, ADDR_STANDBY);
    repeat (20) begin
      @(negedge clock);
      check_value("busy_o", busy, 1'b0);
    end
    check_value("pins_o.nreset", pins.nreset, 1'b1);
    end_test("reset state");

    // config byte with bits 7..3 high, then the channel pattern
    begin_test();
    strobe(SEL_CONFIGURE);
    wait_for_wsr();
    repeat (4) @(negedge clock);
    check_value("config bit count", cfg_cnt, 8'd8);
    check_value("config word", cfg_word, {5'b11111, ctl.config_reg[2:0]});
    check_value("write shift register bit count", wsr_cnt, 8'd8);
    check_value("write shift register word", wsr_word, ctl.chn_pattern);
    end_test("configure");

    begin_test();
    next_cycle();
    ctl.dmode_cont = 1'b0;
    randomize_readout();
    run_single_shot();
    end_test("single shot readout");

    begin_test();
    check_value("stop_cell_o", stop_cell, model_stop_cell);
    end_test("stop cell");

    // armed and waiting, writes before the trigger are errors
    begin_test();
    next_cycle();
    ctl.dmode_cont = 1'b1;
    randomize_readout();
    exp_q.delete();
    done_base = done_cnt;
    strobe(SEL_START);
    repeat (ARMED_HOLD) @(negedge clock);
    check_value("busy_o", busy, 1'b1);
    check_value("done count", done_cnt, done_base);
    build_expected(ctl.readout_mask, ctl.samples);
    strobe(SEL_TRIGGER);
    finish_readout(done_base);
    check_value("stop_cell_o", stop_cell, model_stop_cell);
    end_test("continuous mode");

    // standby and back
    begin_test();
    next_cycle();
    ctl.dmode_cont = 1'b0;
    ctl.standby    = 1'b1;
    wait_for_power(1'b0);
    check_value("pins_o.addr", pins.addr, ADDR_STANDBY);
    check_value("busy_o", busy, 1'b0);
    next_cycle();
    ctl.standby = 1'b0;
    wait_for_power(1'b1);
    next_cycle();
    randomize_readout();
    run_single_shot();
    end_test("standby");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
drs_pkg.sv
drs_channel_mask.sv
drs_serializer.sv
drs_sequencer.sv
drs_sample_gate.sv
drs_top.sv
drs_chip_model.sv
tb_drs.sv

/* Makefile */
# Verilator build and run for the DRS4 readout controller

VERILATOR ?= verilator
TOP       ?= tb_drs
LINT_TOP  ?= drs_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
